// File: logic/aluExec.sv
/*
 * execute stage, ALU operation and next pc resolution
 * combinational, result goes to commit and next pc back to fetch
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module aluExec (
   input  isaPkg::ctrl_t           ctrl,
   input  logic [`CORE_DATA_W-1:0] opA,
   input  logic [`CORE_DATA_W-1:0] opB,
   input  logic [`CORE_DATA_W-1:0] imm11,
   input  logic [`CORE_ADDR_W-1:0] pc,
   output logic [`CORE_DATA_W-1:0] result,
   output logic [`CORE_ADDR_W-1:0] nextPc
);

   logic [`CORE_ADDR_W-1:0] pcPlus1;
   logic                    isZero;
   logic                    taken;

   // arithmetic wraps, no flags
   always_comb begin
      case (ctrl.aluOp)
         isaPkg::ALU_ADD:   result = opA + opB;
         isaPkg::ALU_SUB:   result = opA - opB;
         isaPkg::ALU_XOR:   result = opA ^ opB;
         isaPkg::ALU_ANDN:  result = opA & ~opB;
         isaPkg::ALU_PASSB: result = opB;
         isaPkg::ALU_SLBI:  result = {opA[`CORE_DATA_W-9:0], opB[7:0]};  // shift in low byte
         default:           result = '0;
      endcase
   end

   assign pcPlus1 = pc + 1'b1;
   assign isZero  = (opA == '0);   // rs tested by conditional branches

   always_comb begin
      case (ctrl.brch)
         isaPkg::BR_EQZ: taken = isZero;
         isaPkg::BR_NEZ: taken = !isZero;
         default:        taken = 1'b0;
      endcase
   end

   always_comb begin
      if (ctrl.brch == isaPkg::BR_JUMP)
         nextPc = pcPlus1 + imm11;
      else if (taken)
         nextPc = pcPlus1 + opB;    // opB holds sign extended imm8
      else
         nextPc = pcPlus1;
   end

endmodule

// File: logic/busPkg.sv
/*
 * bus and trace types of the core boundary
 * wishbone classic read channel and the per-instruction commit record
 */
`include "core_consts.svh"

package busPkg;

   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic [`CORE_ADDR_W-1:0] adr;   // word address
   } wbReq_t;

   typedef struct packed {
      logic                    ack;
      logic [`CORE_DATA_W-1:0] dat;   // valid with ack
   } wbRsp_t;

   // one record per retired instruction
   typedef struct packed {
      logic                       valid;
      logic [`CORE_ADDR_W-1:0]    pc;
      logic                       we;
      logic [`CORE_REG_IDX_W-1:0] regIdx;
      logic [`CORE_DATA_W-1:0]    data;   // zero when we is low
   } commit_t;

endpackage

// File: logic/commitStage.sv
/*
 * commit stage, register writeback and retirement trace
 * keeps sticky halted and err, tells fetch to stop on halt
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module commitStage (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic                       exec,
   input  isaPkg::ctrl_t              ctrl,
   input  logic [`CORE_REG_IDX_W-1:0] dst,
   input  logic [`CORE_DATA_W-1:0]    result,
   input  logic [`CORE_ADDR_W-1:0]    pc,
   output logic [`CORE_REG_IDX_W-1:0] wrSel,
   output logic [`CORE_DATA_W-1:0]    wrData,
   output logic                       wrEn,
   output logic                       stop,
   output busPkg::commit_t            commit,
   output logic                       halted,
   output logic                       err
);

   assign wrEn   = exec & ctrl.regWrt;  // write only in the exec cycle
   assign wrSel  = dst;
   assign wrData = result;
   assign stop   = exec & ctrl.halt;    // covers illegal too

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         commit <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         commit.valid <= exec;           // single cycle pulse
         if (exec) begin
            commit.pc     <= pc;
            commit.we     <= ctrl.regWrt;
            commit.regIdx <= dst;
            commit.data   <= ctrl.regWrt ? result : '0;
         end
         if (stop)
            halted <= 1'b1;
         if (exec && ctrl.illegal)
            err <= 1'b1;
      end
   end

endmodule

// File: logic/controlUnit.sv
/*
 * instruction decoder, opcode and function bits to control word
 * purely combinational, unknown opcodes come out as illegal halts
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module controlUnit (
   input  logic [`CORE_DATA_W-1:0] instr,
   output isaPkg::ctrl_t           ctrl
);

   isaPkg::opcode_e opcode;
   logic [1:0]      funct;

   assign opcode = isaPkg::opcode_e'(instr[15:11]);
   assign funct  = instr[1:0];   // register forms only

   always_comb begin
      ctrl       = '0;                  // no write, no branch
      ctrl.aluOp = isaPkg::ALU_ADD;
      ctrl.bSrc  = isaPkg::BSRC_ZERO;
      ctrl.brch  = isaPkg::BR_NONE;
      case (opcode)
         isaPkg::OP_HALT: ctrl.halt = 1'b1;
         isaPkg::OP_NOP: begin
            // retires with no side effect
         end
         isaPkg::OP_RALU: begin
            ctrl.bSrc   = isaPkg::BSRC_REG;
            ctrl.regWrt = 1'b1;
            ctrl.dstSel = 2'd0;            // rd in [4:2]
            case (funct)
               2'b00:   ctrl.aluOp = isaPkg::ALU_ADD;
               2'b01:   ctrl.aluOp = isaPkg::ALU_SUB;
               2'b10:   ctrl.aluOp = isaPkg::ALU_XOR;
               default: ctrl.aluOp = isaPkg::ALU_ANDN;
            endcase
         end
         isaPkg::OP_ADDI, isaPkg::OP_SUBI, isaPkg::OP_XORI, isaPkg::OP_ANDNI: begin
            ctrl.bSrc   = isaPkg::BSRC_IMM5;
            ctrl.regWrt = 1'b1;
            ctrl.dstSel = 2'd1;            // rt in [7:5]
            case (opcode)
               isaPkg::OP_ADDI: ctrl.aluOp = isaPkg::ALU_ADD;
               isaPkg::OP_SUBI: ctrl.aluOp = isaPkg::ALU_SUB;
               isaPkg::OP_XORI: ctrl.aluOp = isaPkg::ALU_XOR;
               default:         ctrl.aluOp = isaPkg::ALU_ANDN;
            endcase
            // logical immediates are unsigned
            ctrl.zeroExt = (opcode == isaPkg::OP_XORI) || (opcode == isaPkg::OP_ANDNI);
         end
         isaPkg::OP_LBI, isaPkg::OP_SLBI: begin
            ctrl.bSrc    = isaPkg::BSRC_IMM8;
            ctrl.regWrt  = 1'b1;
            ctrl.dstSel  = 2'd2;           // rs is both source and target
            ctrl.zeroExt = (opcode == isaPkg::OP_SLBI);
            ctrl.aluOp   = (opcode == isaPkg::OP_SLBI) ? isaPkg::ALU_SLBI : isaPkg::ALU_PASSB;
         end
         isaPkg::OP_BEQZ, isaPkg::OP_BNEZ: begin
            ctrl.bSrc = isaPkg::BSRC_IMM8;  // signed offset rides on operand b
            ctrl.brch = (opcode == isaPkg::OP_BEQZ) ? isaPkg::BR_EQZ : isaPkg::BR_NEZ;
         end
         isaPkg::OP_J: ctrl.brch = isaPkg::BR_JUMP;
         default: begin
            ctrl.illegal = 1'b1;
            ctrl.halt    = 1'b1;           // stop fetching on garbage
         end
      endcase
   end

   // a writing instruction never redirects the pc
   always_comb begin
      aNoWrtBrch: assert final (!(ctrl.regWrt && ctrl.brch != isaPkg::BR_NONE))
         else $error("regWrt with branch type, instr %h", instr);
   end

endmodule

// File: logic/coreTop.sv
/*
 * top of the multicycle core, fetch, decode, execute and commit
 * instruction bus and commit trace are the only external ports
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module coreTop (
   input  logic            clk,
   input  logic            rstN,
   output busPkg::wbReq_t  wbReq,
   input  busPkg::wbRsp_t  wbRsp,
   output busPkg::commit_t commit,
   output logic            halted,
   output logic            err
);

   logic [`CORE_DATA_W-1:0]    instr;
   logic [`CORE_ADDR_W-1:0]    pc;
   logic [`CORE_ADDR_W-1:0]    nextPc;
   logic                       exec;
   logic                       stop;
   isaPkg::ctrl_t              ctrl;
   logic [`CORE_DATA_W-1:0]    opA;
   logic [`CORE_DATA_W-1:0]    opB;
   logic [`CORE_DATA_W-1:0]    imm11;
   logic [`CORE_DATA_W-1:0]    result;
   logic [`CORE_REG_IDX_W-1:0] dst;
   logic [`CORE_REG_IDX_W-1:0] wrSel;
   logic [`CORE_DATA_W-1:0]    wrData;
   logic                       wrEn;

   fetchUnit uFetch (.clk(clk), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp), .nextPc(nextPc),
                     .stop(stop), .instr(instr), .pc(pc), .exec(exec));

   decodeStage uDecode (.clk(clk), .rstN(rstN), .instr(instr), .wrSel(wrSel), .wrData(wrData),
                        .wrEn(wrEn), .ctrl(ctrl), .opA(opA), .opB(opB), .imm11(imm11), .dst(dst));

   aluExec uExec (.ctrl(ctrl), .opA(opA), .opB(opB), .imm11(imm11), .pc(pc),
                  .result(result), .nextPc(nextPc));

   commitStage uCommit (.clk(clk), .rstN(rstN), .exec(exec), .ctrl(ctrl), .dst(dst),
                        .result(result), .pc(pc), .wrSel(wrSel), .wrData(wrData), .wrEn(wrEn),
                        .stop(stop), .commit(commit), .halted(halted), .err(err));

endmodule

// File: logic/core_consts.svh
/*
 * global sizing for the 16-bit multicycle core
 * included by packages and RTL that need widths or the reset vector
 */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path and instruction word width
`define CORE_DATA_W 16
// architectural register count, index width follows from it
`define CORE_REG_CNT 8
`define CORE_REG_IDX_W $clog2(`CORE_REG_CNT)
// word address width on the instruction bus, pc counts words
`define CORE_ADDR_W 16
`define CORE_RESET_PC 16'h0000  // first fetch address

`endif

// File: logic/decodeStage.sv
/*
 * decode stage, control decode, register read and operand selection
 * feeds aluExec, takes the write port from commitStage
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module decodeStage (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic [`CORE_DATA_W-1:0]    instr,
   input  logic [`CORE_REG_IDX_W-1:0] wrSel,   // from commit
   input  logic [`CORE_DATA_W-1:0]    wrData,
   input  logic                       wrEn,
   output isaPkg::ctrl_t              ctrl,
   output logic [`CORE_DATA_W-1:0]    opA,
   output logic [`CORE_DATA_W-1:0]    opB,
   output logic [`CORE_DATA_W-1:0]    imm11,   // jump offset
   output logic [`CORE_REG_IDX_W-1:0] dst
);

   logic [`CORE_DATA_W-1:0] imm5;
   logic [`CORE_DATA_W-1:0] imm8;
   logic [`CORE_DATA_W-1:0] regB;

   controlUnit uCtrl (
      .instr (instr),
      .ctrl  (ctrl)
   );

   // rs on port a, rt on port b
   regFile uRegs (
      .clk    (clk),
      .rstN   (rstN),
      .rdSelA (instr[10:8]),
      .rdSelB (instr[7:5]),
      .wrSel  (wrSel),
      .wrData (wrData),
      .wrEn   (wrEn),
      .rdA    (opA),
      .rdB    (regB)
   );

   assign imm5  = ctrl.zeroExt ? {{(`CORE_DATA_W-5){1'b0}}, instr[4:0]}
                               : {{(`CORE_DATA_W-5){instr[4]}}, instr[4:0]};
   assign imm8  = ctrl.zeroExt ? {{(`CORE_DATA_W-8){1'b0}}, instr[7:0]}
                               : {{(`CORE_DATA_W-8){instr[7]}}, instr[7:0]};
   assign imm11 = {{(`CORE_DATA_W-11){instr[10]}}, instr[10:0]};  // always signed

   always_comb begin
      case (ctrl.bSrc)
         isaPkg::BSRC_REG:  opB = regB;
         isaPkg::BSRC_IMM5: opB = imm5;
         isaPkg::BSRC_IMM8: opB = imm8;   // also branch offset
         default:           opB = '0;
      endcase
   end

   always_comb begin
      case (ctrl.dstSel)
         2'd1:    dst = instr[7:5];       // immediate forms
         2'd2:    dst = instr[10:8];      // lbi, slbi
         default: dst = instr[4:2];
      endcase
   end

endmodule

// File: logic/fetchUnit.sv
/*
 * instruction fetch and sequencing for the multicycle core
 * wishbone classic read master that holds pc and the fetched word
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module fetchUnit (
   input  logic                    clk,
   input  logic                    rstN,
   output busPkg::wbReq_t          wbReq,
   input  busPkg::wbRsp_t          wbRsp,
   input  logic [`CORE_ADDR_W-1:0] nextPc,  // from aluExec
   input  logic                    stop,    // halt or illegal in exec
   output logic [`CORE_DATA_W-1:0] instr,
   output logic [`CORE_ADDR_W-1:0] pc,
   output logic                    exec     // one cycle per instruction
);

   typedef enum logic [1:0] {IDLE, REQ, EXEC, STOPPED} state_e;

   state_e state;
   state_e stateNxt;

   always_comb begin
      stateNxt = state;
      case (state)
         IDLE: stateNxt = REQ;             // first fetch right after reset
         REQ: begin
            if (wbRsp.ack)
               stateNxt = EXEC;           // wait states only stretch this phase
         end
         EXEC: stateNxt = stop ? STOPPED : REQ;
         default: stateNxt = STOPPED;      // parked until reset
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= IDLE;
         pc    <= `CORE_RESET_PC;
      end else begin
         state <= stateNxt;
         if (state == EXEC)
            pc <= nextPc;                 // next request goes out with the new pc
      end
   end

   // instruction register captured in the ack cycle
   always_ff @(posedge clk) begin
      if (state == REQ && wbRsp.ack)
         instr <= wbRsp.dat;
   end

   assign exec      = (state == EXEC);
   assign wbReq.cyc = (state == REQ);
   assign wbReq.stb = (state == REQ);  // single beat so stb follows cyc
   assign wbReq.adr = pc;

   // a pending request keeps its strobe and address until ack
   aAdrHold: assert property (@(posedge clk) disable iff (!rstN)
      (wbReq.stb && !wbRsp.ack) |=> (wbReq.stb && $stable(wbReq.adr)));

endmodule

// File: logic/isaPkg.sv
/*
 * instruction set types shared by decode and execute
 * opcode and ALU encodings plus the decoded control word
 */
package isaPkg;

   // instr[15:11], anything not listed here is illegal
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_SLBI  = 5'b10010,
      OP_LBI   = 5'b11000,
      OP_RALU  = 5'b11011   // register forms, function in [1:0]
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,              // a - b
      ALU_XOR,
      ALU_ANDN,             // a & ~b
      ALU_PASSB,            // lbi
      ALU_SLBI              // (a << 8) | b[7:0]
   } aluOp_e;

   // operand b source
   typedef enum logic [1:0] {BSRC_REG, BSRC_IMM5, BSRC_IMM8, BSRC_ZERO} bSrc_e;

   typedef enum logic [1:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_JUMP} brch_e;

   typedef struct packed {
      aluOp_e     aluOp;
      bSrc_e      bSrc;
      logic       zeroExt;  // imm5/imm8 zero extended when set
      brch_e      brch;
      logic       regWrt;
      logic [1:0] dstSel;   // 0 rd, 1 rt, 2 rs
      logic       halt;
      logic       illegal;
   } ctrl_t;

endpackage

// File: logic/regFile.sv
/*
 * architectural register file, eight 16-bit entries
 * two combinational read ports and one synchronous write port
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module regFile (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic [`CORE_REG_IDX_W-1:0] rdSelA,
   input  logic [`CORE_REG_IDX_W-1:0] rdSelB,
   input  logic [`CORE_REG_IDX_W-1:0] wrSel,
   input  logic [`CORE_DATA_W-1:0]    wrData,
   input  logic                       wrEn,
   output logic [`CORE_DATA_W-1:0]    rdA,
   output logic [`CORE_DATA_W-1:0]    rdB
);

   logic [`CORE_DATA_W-1:0] regs [`CORE_REG_CNT];  // r0 is a normal register

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `CORE_REG_CNT; i++)
            regs[i] <= '0;
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   // write lands before the next instruction reads
   assign rdA = regs[rdSelA];
   assign rdB = regs[rdSelB];

endmodule

// File: project.f
+incdir+logic
+incdir+verif
logic/isaPkg.sv
logic/busPkg.sv
logic/regFile.sv
logic/controlUnit.sv
logic/decodeStage.sv
logic/aluExec.sv
logic/fetchUnit.sv
logic/commitStage.sv
logic/coreTop.sv
verif/coreTb.sv

// File: verif/coreTbTasks.svh
/*
 * helpers and directed tests of coreTb that sit inside the module
 * reference model runs the program from mem into expQ before each run
 */
function automatic logic stepLfsr();
   logic fb;
   fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // taps 16 14 13 11
   lfsr = {lfsr[14:0], fb};
   return fb;
endfunction

task automatic checkEq(input string name, input logic [31:0] expV, input logic [31:0] gotV);
   if (expV !== gotV) begin
      $display("ERR %s exp %h got %h", name, expV, gotV);
      $display("SIMULATION FAILED");
      $fatal(1);
   end
endtask

function automatic logic [15:0] iFmt(logic [4:0] op, logic [2:0] rs, logic [2:0] rt,
                                     logic [4:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic logic [15:0] rFmt(logic [1:0] fn, logic [2:0] rs, logic [2:0] rt,
                                     logic [2:0] rd);
   return {isaPkg::OP_RALU, rs, rt, rd, fn};
endfunction

function automatic logic [15:0] bFmt(logic [4:0] op, logic [2:0] rs, logic [7:0] imm);
   return {op, rs, imm};
endfunction

// unused words hold an illegal opcode tagged with their address
task automatic clearMem();
   for (int i = 0; i < 256; i++) mem[i] = {5'b11111, 3'b000, i[7:0]};
endtask

// executes mem from pc 0 by the ISA rules
task automatic runModel();
   logic [15:0]     r [8];
   logic [15:0]     pc;
   logic [15:0]     ins;
   logic [15:0]     nxt;
   logic [15:0]     d;
   logic [15:0]     s5;
   logic [15:0]     z5;
   logic [15:0]     s8;
   logic            we;
   logic            done;
   logic [2:0]      idx;
   busPkg::commit_t c;
   expQ.delete();
   expErr = 1'b0;
   pc     = 16'd0;
   done   = 1'b0;
   for (int k = 0; k < 8; k++)
      r[k] = 16'd0;
   for (int n = 0; n < 64 && !done; n++) begin
      ins = mem[pc[7:0]];
      nxt = pc + 16'd1;
      we  = 1'b0;
      d   = 16'd0;
      idx = ins[4:2];                    // rd
      s5  = {{11{ins[4]}}, ins[4:0]};
      z5  = {11'd0, ins[4:0]};
      s8  = {{8{ins[7]}}, ins[7:0]};
      case (ins[15:11])
         isaPkg::OP_RALU: begin
            we = 1'b1;
            case (ins[1:0])
               2'd0: d = r[ins[10:8]] + r[ins[7:5]];
               2'd1: d = r[ins[10:8]] - r[ins[7:5]];
               2'd2: d = r[ins[10:8]] ^ r[ins[7:5]];
               default: d = r[ins[10:8]] & ~r[ins[7:5]];
            endcase
         end
         isaPkg::OP_ADDI, isaPkg::OP_SUBI, isaPkg::OP_XORI, isaPkg::OP_ANDNI: begin
            we  = 1'b1;
            idx = ins[7:5];              // rt
            case (ins[12:11])
               2'd0: d = r[ins[10:8]] + s5;
               2'd1: d = r[ins[10:8]] - s5;
               2'd2: d = r[ins[10:8]] ^ z5;
               default: d = r[ins[10:8]] & ~z5;
            endcase
         end
         isaPkg::OP_LBI, isaPkg::OP_SLBI: begin
            we  = 1'b1;
            idx = ins[10:8];             // rs
            if (ins[15:11] == isaPkg::OP_LBI)
               d = s8;
            else
               d = {r[ins[10:8]][7:0], ins[7:0]};
         end
         isaPkg::OP_BEQZ:  if (r[ins[10:8]] == 16'd0) nxt = pc + 16'd1 + s8;
         isaPkg::OP_BNEZ:  if (r[ins[10:8]] != 16'd0) nxt = pc + 16'd1 + s8;
         isaPkg::OP_J:     nxt = pc + 16'd1 + {{5{ins[10]}}, ins[10:0]};
         isaPkg::OP_NOP:   ;
         isaPkg::OP_HALT:  done = 1'b1;
         default: begin
            done   = 1'b1;
            expErr = 1'b1;
         end
      endcase
      c        = '0;
      c.valid  = 1'b1;
      c.pc     = pc;
      c.we     = we;
      c.regIdx = idx;
      c.data   = d;
      expQ.push_back(c);
      if (we)
         r[idx] = d;
      pc = nxt;
   end
endtask

// reset held for 5 cycles while the outputs stay quiet
task automatic applyReset();
   rstN     = 1'b0;
   ackCount = 0;
   adrQ.delete();
   gotQ.delete();
   repeat (5) begin
      @(negedge clk);
      checkEq("wbReq.cyc", 0, wbReq.cyc);
      checkEq("wbReq.stb", 0, wbReq.stb);
      checkEq("commit.valid", 0, commit.valid);
      checkEq("halted", 0, halted);
      checkEq("err", 0, err);
   end
   rstN = 1'b1;
endtask

task automatic runProgram(input logic delay);
   int reqs;
   useDelay = delay;
   runModel();
   applyReset();
   while (!halted) @(negedge clk);
   reqs = adrQ.size();
   repeat (20) begin
      @(negedge clk);
      checkEq("wbReq.cyc", 0, wbReq.cyc);   // parked after halt
      checkEq("wbReq.stb", 0, wbReq.stb);
   end
   checkEq("request count", reqs, adrQ.size());
   checkEq("commit count", expQ.size(), gotQ.size());
   checkEq("ack count", gotQ.size(), ackCount);
   for (int i = 0; i < expQ.size(); i++) begin
      checkEq("wbReq.adr", expQ[i].pc, adrQ[i]);
      checkEq("commit.pc", expQ[i].pc, gotQ[i].pc);
      checkEq("commit.we", expQ[i].we, gotQ[i].we);
      if (expQ[i].we) checkEq("commit.reg", expQ[i].regIdx, gotQ[i].regIdx);
      checkEq("commit.data", expQ[i].data, gotQ[i].data);
   end
   checkEq("err", expErr, err);
endtask

task automatic testReset();
   clearMem();
   mem[0] = 16'h0000;                 // halt
   applyReset();
   @(negedge clk);                    // first cycle after release
   checkEq("wbReq.cyc", 1, wbReq.cyc);
   checkEq("wbReq.stb", 1, wbReq.stb);
   checkEq("wbReq.adr", 0, wbReq.adr);
   checkEq("commit.valid", 0, commit.valid);
   checkEq("halted", 0, halted);
   checkEq("err", 0, err);
   while (!halted) @(negedge clk);    // let the halt retire before the next load
endtask

task automatic loadArith();
   clearMem();
   mem[0]  = bFmt(isaPkg::OP_LBI, 1, 8'hFB);   // r1 = -5
   mem[1]  = bFmt(isaPkg::OP_LBI, 2, 8'd100);
   mem[2]  = rFmt(0, 1, 2, 3);
   mem[3]  = rFmt(1, 2, 1, 4);
   mem[4]  = rFmt(2, 1, 2, 5);
   mem[5]  = rFmt(3, 1, 2, 6);
   mem[6]  = iFmt(isaPkg::OP_ADDI, 1, 7, 5'h1D);  // sign extended -3
   mem[7]  = iFmt(isaPkg::OP_SUBI, 2, 3, 5'd7);
   mem[8]  = iFmt(isaPkg::OP_XORI, 1, 4, 5'h1F);  // zero extended 31
   mem[9]  = iFmt(isaPkg::OP_ANDNI, 2, 5, 5'h14);
   mem[10] = 16'h0000;
endtask

task automatic testArith();
   loadArith();
   runProgram(1'b0);
endtask

task automatic testConst();
   clearMem();
   mem[0] = bFmt(isaPkg::OP_LBI, 1, 8'h12);
   mem[1] = bFmt(isaPkg::OP_SLBI, 1, 8'h34);
   mem[2] = bFmt(isaPkg::OP_LBI, 2, 8'hAB);
   mem[3] = bFmt(isaPkg::OP_SLBI, 2, 8'hCD);
   mem[4] = bFmt(isaPkg::OP_SLBI, 2, 8'hEF);
   mem[5] = 16'h0000;
   runProgram(1'b0);
endtask

task automatic testBranch();
   clearMem();
   mem[0]  = bFmt(isaPkg::OP_LBI, 1, 8'd0);
   mem[1]  = bFmt(isaPkg::OP_BEQZ, 1, 8'd2);    // taken
   mem[2]  = bFmt(isaPkg::OP_LBI, 2, 8'd1);
   mem[4]  = bFmt(isaPkg::OP_BNEZ, 1, 8'd5);    // not taken
   mem[5]  = bFmt(isaPkg::OP_LBI, 3, 8'd7);
   mem[6]  = bFmt(isaPkg::OP_BNEZ, 3, 8'd1);    // taken
   mem[7]  = 16'h0000;
   mem[8]  = bFmt(isaPkg::OP_BEQZ, 3, 8'd3);    // not taken
   mem[9]  = {isaPkg::OP_J, 11'd2};             // forward
   mem[10] = 16'h0000;
   mem[11] = {isaPkg::OP_J, 11'd3};
   mem[12] = iFmt(isaPkg::OP_ADDI, 3, 4, 5'd1);
   mem[13] = {isaPkg::OP_J, 11'h7FD};           // backward to 11
   mem[15] = 16'h0000;
   runProgram(1'b0);
endtask

task automatic testBackPressure();
   loadArith();
   runProgram(1'b1);
endtask

task automatic testIllegal();
   clearMem();
   mem[0] = bFmt(isaPkg::OP_LBI, 1, 8'd5);
   mem[1] = 16'hF800;                            // opcode 11111
   runProgram(1'b1);
   checkEq("err", 1, err);
endtask

// File: verif/coreTb.sv
/*
 * testbench for coreTop, wishbone memory model with LFSR wait states,
 * commit and fetch monitors, watchdog and the directed test sequence
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module coreTb;

   localparam int ALL_INSTR = 80;   // instructions over all programs, with margin

   logic            clk;
   logic            rstN;
   busPkg::wbReq_t  wbReq;
   busPkg::wbRsp_t  wbRsp;
   busPkg::commit_t commit;
   logic            halted;
   logic            err;

   logic [`CORE_DATA_W-1:0] mem [256];
   logic [15:0]             lfsr;
   logic                    useDelay;     // random ack wait states when set
   logic                    pending;
   logic [1:0]              waitLeft;
   int                      ackCount;
   logic [15:0]             adrQ [$];     // address of every request
   busPkg::commit_t         gotQ [$];
   busPkg::commit_t         expQ [$];
   logic                    expErr;

   `include "coreTbTasks.svh"

   coreTop UUT (.clk(clk), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp), .commit(commit),
                .halted(halted), .err(err));

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // memory model, one ack per request after 0..3 wait cycles
   always @(negedge clk) begin
      if (!rstN) begin
         wbRsp   = '0;
         pending = 1'b0;
      end else if (wbRsp.ack) begin
         wbRsp = '0;                       // ack lasts one cycle
      end else if (wbReq.cyc && wbReq.stb) begin
         if (!pending) begin
            pending  = 1'b1;
            waitLeft = 2'd0;
            if (useDelay) begin
               waitLeft[1] = stepLfsr();
               waitLeft[0] = stepLfsr();
            end
            adrQ.push_back(wbReq.adr);
         end
         if (waitLeft == 2'd0) begin
            wbRsp.ack = 1'b1;
            wbRsp.dat = mem[wbReq.adr[7:0]];
            pending   = 1'b0;
            ackCount++;
         end else begin
            waitLeft--;
         end
      end
   end

   always @(negedge clk)
      if (rstN && commit.valid) gotQ.push_back(commit);   // registered, stable here

   initial begin
      #(ALL_INSTR * 200 * 20);
      $display("watchdog expired before the tests finished");
      $display("SIMULATION FAILED");
      $fatal(1);
   end

   initial begin
      rstN     = 1'b0;
      wbRsp    = '0;
      useDelay = 1'b0;
      lfsr     = 16'd76;
      testReset();
      testArith();
      testConst();
      testBranch();
      testBackPressure();
      testIllegal();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
